// ==== all.f ====
verilog/scanner_pkg.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/main_control.sv
verilog/tdc_spi_master.sv
verilog/tdc_control.sv
verilog/sync_fifo.sv
verilog/fifo_manager.sv
verilog/scanner_top.sv
sim/tdc_slave_model.sv
sim/tb_scanner.sv

// ==== Makefile ====
TOP = tb_scanner

.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f all.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== sim/tb_scanner.sv ====
`timescale 1ns/1ps

module tb_scanner;

  localparam int NUM_CHANNELS    = 2;
  localparam int SHOT_DIV        = 300;
  localparam int TDC_SPI_DIV     = 2;
  localparam int CLKS_PER_BIT    = 8;
  localparam int FIFO_DEPTH_LOG2 = 2;
  // about 20 words at 40 bit times each plus setup margin
  localparam int TIMEOUT_CYCLES  = 24 * 40 * CLKS_PER_BIT + 2000;
  localparam logic [7:0] PAUSE_FLAG = 8'(1 << scanner_pkg::CMD_PAUSE_BIT);

  logic                    clk = 1'b0;
  logic                    rst;
  logic                    serial_in;
  wire [NUM_CHANNELS-1:0]  tdc_intb;
  wire [NUM_CHANNELS-1:0]  tdc_dout;
  wire [NUM_CHANNELS-1:0]  tdc_enable;
  wire [NUM_CHANNELS-1:0]  tdc_start_signal;
  wire [NUM_CHANNELS-1:0]  tdc_cs;
  wire [NUM_CHANNELS-1:0]  tdc_sck;
  wire [NUM_CHANNELS-1:0]  tdc_mosi;
  wire                     serial_out;

  // transaction reports from the TDC models
  wire [NUM_CHANNELS-1:0]  model_busy;
  wire [NUM_CHANNELS-1:0]  txn_done;
  wire [7:0]               opcode0;
  wire [7:0]               opcode1;
  wire [7:0]               edges0;
  wire [7:0]               edges1;
  wire [23:0]              result0;
  wire [23:0]              result1;

  // expected results per channel in delivery order
  logic [23:0] exp_q0 [$];
  logic [23:0] exp_q1 [$];

  // channels that must not fire right now
  logic [NUM_CHANNELS-1:0] shot_forbid;
  logic                    idle_phase;
  int                      shot_count [NUM_CHANNELS];
  int                      word_count;
  int                      cycle_count;

  always #10 clk = ~clk;

  scanner_top #(
    .NUM_CHANNELS    (NUM_CHANNELS),
    .SHOT_DIV        (SHOT_DIV),
    .TDC_SPI_DIV     (TDC_SPI_DIV),
    .CLKS_PER_BIT    (CLKS_PER_BIT),
    .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
  ) dut_i (
    .clk              (clk),
    .rst              (rst),
    .serial_in        (serial_in),
    .tdc_intb         (tdc_intb),
    .tdc_dout         (tdc_dout),
    .tdc_enable       (tdc_enable),
    .tdc_start_signal (tdc_start_signal),
    .tdc_cs           (tdc_cs),
    .tdc_sck          (tdc_sck),
    .tdc_mosi         (tdc_mosi),
    .serial_out       (serial_out)
  );

  tdc_slave_model #(
    .CHAN(0)
  ) chan0_tdc (
    .clk          (clk),
    .rst          (rst),
    .start_signal (tdc_start_signal[0]),
    .cs           (tdc_cs[0]),
    .sck          (tdc_sck[0]),
    .mosi         (tdc_mosi[0]),
    .intb         (tdc_intb[0]),
    .dout         (tdc_dout[0]),
    .busy         (model_busy[0]),
    .txn_done     (txn_done[0]),
    .txn_opcode   (opcode0),
    .txn_edges    (edges0),
    .txn_result   (result0)
  );

  tdc_slave_model #(
    .CHAN(1)
  ) chan1_tdc (
    .clk          (clk),
    .rst          (rst),
    .start_signal (tdc_start_signal[1]),
    .cs           (tdc_cs[1]),
    .sck          (tdc_sck[1]),
    .mosi         (tdc_mosi[1]),
    .intb         (tdc_intb[1]),
    .dout         (tdc_dout[1]),
    .busy         (model_busy[1]),
    .txn_done     (txn_done[1]),
    .txn_opcode   (opcode1),
    .txn_edges    (edges1),
    .txn_result   (result1)
  );

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic report_value_error(input string name, input logic [31:0] expected,
                                    input logic [31:0] actual);
    report_failure($sformatf("Error at %0t: %s expected 0x%0h, got 0x%0h",
                             $time, name, expected, actual));
  endtask

  // 8N1 frame, lsb first
  task automatic send_command(input logic [7:0] cmd);
    logic [9:0] frame;
    frame = {1'b1, cmd, 1'b0};
    for (int b = 0; b < 10; b++) begin
      serial_in <= frame[b];
      repeat (CLKS_PER_BIT) @(posedge clk);
    end
  endtask

  // enables follow the command a cycle after the byte strobe
  task automatic expect_enable(input logic [NUM_CHANNELS-1:0] value);
    int n;
    n = 0;
    @(negedge clk);
    while (tdc_enable != value && n < 4) begin
      @(negedge clk);
      n++;
    end
    assert (tdc_enable == value)
      else report_value_error("tdc_enable", 32'(value), 32'(tdc_enable));
    @(posedge clk);
  endtask

  task automatic check_transaction(input int ch, input logic [7:0] opcode,
                                   input logic [7:0] edges, input logic [23:0] res);
    assert (opcode == scanner_pkg::TDC_READ_OPCODE)
      else report_value_error($sformatf("tdc_mosi[%0d] first byte", ch),
                              32'(scanner_pkg::TDC_READ_OPCODE), 32'(opcode));
    assert (edges == 8'd32)
      else report_value_error($sformatf("tdc_sck[%0d] rising edges", ch), 32'd32, 32'(edges));
    if (ch == 0) begin
      exp_q0.push_back(res);
    end else begin
      exp_q1.push_back(res);
    end
  endtask

  task automatic check_word(input logic [31:0] w);
    logic [7:0]  tag;
    logic [23:0] expected;
    tag = w[31:24];
    assert (tag < NUM_CHANNELS)
      else report_failure($sformatf("Error at %0t: serial_out tag expected below %0d, got %0d",
                                    $time, NUM_CHANNELS, tag));
    assert (tdc_enable[tag[0]])
      else report_failure($sformatf("Word tagged %0d arrived while its channel was disabled",
                                    tag));
    if (tag == 8'd0) begin
      assert (exp_q0.size() > 0)
        else report_failure("Word from channel 0 arrived with no measurement outstanding");
      expected = exp_q0.pop_front();
    end else begin
      assert (exp_q1.size() > 0)
        else report_failure("Word from channel 1 arrived with no measurement outstanding");
      expected = exp_q1.pop_front();
    end
    assert (w[23:0] == expected)
      else report_value_error($sformatf("serial_out channel %0d result", tag),
                              {8'h00, expected}, {8'h00, w[23:0]});
    word_count++;
  endtask

  // quiet outputs between reset and the first command
  always @(negedge clk) begin
    if (!rst && idle_phase) begin
      assert (tdc_cs == '1)
        else report_value_error("tdc_cs", 32'(2'b11), 32'(tdc_cs));
      assert (serial_out == 1'b1)
        else report_value_error("serial_out", 32'd1, 32'(serial_out));
      assert (tdc_enable == '0)
        else report_value_error("tdc_enable", 32'd0, 32'(tdc_enable));
    end
  end

  // shot counting and silent channel check
  always @(negedge clk) begin
    if (!rst) begin
      for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
        if (tdc_start_signal[ch]) shot_count[ch]++;
      end
      assert ((tdc_start_signal & shot_forbid) == '0)
        else report_failure($sformatf("Start pulse at %0t on a silent channel, pulses %b",
                                      $time, tdc_start_signal));
    end
  end

  always @(negedge clk) begin
    if (!rst) begin
      if (txn_done[0]) check_transaction(0, opcode0, edges0, result0);
      if (txn_done[1]) check_transaction(1, opcode1, edges1, result1);
    end
  end

  // rebuild bytes at mid bit, four bytes per word
  initial begin : serial_monitor
    logic [7:0]  rx_byte;
    logic [31:0] word;
    int          nbytes;
    nbytes = 0;
    word   = '0;
    forever begin
      @(negedge clk);
      if (!rst && serial_out == 1'b0) begin
        repeat (CLKS_PER_BIT / 2) @(negedge clk);
        assert (serial_out == 1'b0)
          else report_failure("Start bit on serial_out did not last to mid bit");
        for (int b = 0; b < 8; b++) begin
          repeat (CLKS_PER_BIT) @(negedge clk);
          rx_byte[b] = serial_out;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        assert (serial_out == 1'b1)
          else report_failure("Missing stop bit on serial_out");
        word = {word[23:0], rx_byte};
        nbytes++;
        if (nbytes == 4) begin
          check_word(word);
          nbytes = 0;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      report_failure($sformatf("Timeout: run did not finish within %0d cycles",
                               TIMEOUT_CYCLES));
    end
  end

  initial begin : main_sequence
    int shots_before;
    int target;
    rst         = 1'b1;
    serial_in   = 1'b1;
    shot_forbid = '1;
    idle_phase  = 1'b1;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    // nothing fires before a command
    repeat (50) @(posedge clk);
    idle_phase  <= 1'b0;
    shot_forbid <= '0;

    // both channels on
    send_command(8'h03);
    expect_enable(2'b11);
    while (shot_count[0] == 0 || shot_count[1] == 0) @(posedge clk);
    // shots outpace the UART so the FIFO fills
    while (word_count < 10) @(posedge clk);

    // pause with enables kept
    send_command(PAUSE_FLAG | 8'h03);
    expect_enable(2'b11);
    shot_forbid <= 2'b11;
    // held and queued words drain out
    while (exp_q0.size() != 0 || exp_q1.size() != 0 || model_busy != '0) begin
      @(posedge clk);
    end

    // unpause with channel 0 only
    send_command(8'h01);
    expect_enable(2'b01);
    shot_forbid  <= 2'b10;
    shots_before = shot_count[0];
    while (shot_count[0] == shots_before) @(posedge clk);
    target = (word_count + 2 > 20) ? word_count + 2 : 20;
    while (word_count < target) @(posedge clk);

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// ==== sim/tdc_slave_model.sv ====
`timescale 1ns/1ps

module tdc_slave_model #(
  parameter int CHAN = 0
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        start_signal,
  input  logic        cs,
  input  logic        sck,
  input  logic        mosi,
  output logic        intb,
  output logic        dout,
  output logic        busy,
  output logic        txn_done,
  output logic [7:0]  txn_opcode,
  output logic [7:0]  txn_edges,
  output logic [23:0] txn_result
);

  logic [31:0] lcg_state;
  logic [31:0] out_shift;
  logic [23:0] cur_result;
  logic [7:0]  mosi_shift;
  logic [7:0]  edge_cnt;
  logic [3:0]  delay;
  logic        cs_q;
  logic        sck_q;
  // pins idle before the first clock
  logic        intb_q = 1'b1;
  logic        dout_q = 1'b0;

  assign intb = intb_q;
  assign dout = dout_q;

  // LCG step for measurement values and interrupt latency
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      // each channel gets its own stream from the base seed
      lcg_state <= 32'd28739 + 32'(CHAN) * 32'd7919;
      intb_q    <= 1'b1;
      dout_q    <= 1'b0;
      busy      <= 1'b0;
      txn_done  <= 1'b0;
      delay     <= '0;
      cs_q      <= 1'b1;
      sck_q     <= 1'b0;
      edge_cnt  <= '0;
    end else begin
      txn_done <= 1'b0;
      cs_q     <= cs;
      sck_q    <= sck;
      // new measurement per shot
      if (start_signal) begin
        cur_result <= lcg_state[30:7];
        delay      <= 4'd2 + {1'b0, lcg_state[18:16]};
        lcg_state  <= lcg_next(lcg_state);
        busy       <= 1'b1;
      end else if (delay != 4'd0) begin
        delay <= delay - 1'b1;
        // interrupt after a variable latency
        if (delay == 4'd1) intb_q <= 1'b0;
      end
      // cs falling releases the interrupt
      if (cs_q && !cs) begin
        intb_q    <= 1'b1;
        // opcode byte clocks zeros, result follows msb first
        dout_q    <= 1'b0;
        out_shift <= {7'h00, cur_result, 1'b0};
        edge_cnt  <= '0;
      end
      // mode 0, next bit after each falling sck
      if (!cs && sck_q && !sck) begin
        dout_q    <= out_shift[31];
        out_shift <= {out_shift[30:0], 1'b0};
      end
      // rising sck, count and capture the command byte
      if (!cs && !sck_q && sck) begin
        edge_cnt <= edge_cnt + 1'b1;
        if (edge_cnt < 8'd8) mosi_shift <= {mosi_shift[6:0], mosi};
      end
      // cs rising ends the transaction
      if (!cs_q && cs) begin
        txn_done   <= 1'b1;
        txn_opcode <= mosi_shift;
        txn_edges  <= edge_cnt;
        txn_result <= cur_result;
        busy       <= 1'b0;
      end
    end
  end

endmodule

// ==== verilog/scanner_top.sv ====
`timescale 1ns/1ps

module scanner_top #(
  parameter int NUM_CHANNELS    = 2,
  parameter int SHOT_DIV        = 3571,
  parameter int TDC_SPI_DIV     = 4,
  parameter int CLKS_PER_BIT    = 12,
  parameter int FIFO_DEPTH_LOG2 = 6
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    serial_in,
  input  logic [NUM_CHANNELS-1:0] tdc_intb,
  input  logic [NUM_CHANNELS-1:0] tdc_dout,
  output logic [NUM_CHANNELS-1:0] tdc_enable,
  output wire  [NUM_CHANNELS-1:0] tdc_start_signal,
  output wire  [NUM_CHANNELS-1:0] tdc_cs,
  output wire  [NUM_CHANNELS-1:0] tdc_sck,
  output wire  [NUM_CHANNELS-1:0] tdc_mosi,
  output logic                    serial_out
);

  logic pause;

  // per channel handshakes packed by channel index
  wire [NUM_CHANNELS-1:0]                     spi_start;
  wire [NUM_CHANNELS-1:0]                     spi_busy;
  wire [NUM_CHANNELS-1:0]                     spi_cs_end;
  wire scanner_pkg::byte_t [NUM_CHANNELS-1:0] spi_data_in;
  wire scanner_pkg::byte_t [NUM_CHANNELS-1:0] spi_data_out;
  wire [NUM_CHANNELS-1:0]                     wr_en;
  wire [NUM_CHANNELS-1:0]                     writing_done;
  wire scanner_pkg::tdc_result_t [NUM_CHANNELS-1:0] result;

  // enables drive the TDC enable pins as well
  main_control #(
    .NUM_CHANNELS (NUM_CHANNELS),
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) main_control_i (
    .clk       (clk),
    .rst       (rst),
    .serial_in (serial_in),
    .enable    (tdc_enable),
    .pause     (pause)
  );

  for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_chan
    tdc_control #(
      .SHOT_DIV(SHOT_DIV)
    ) tdc_control_i (
      .clk          (clk),
      .rst          (rst),
      .enable       (tdc_enable[i]),
      .pause        (pause),
      .intb         (tdc_intb[i]),
      .spi_busy     (spi_busy[i]),
      .spi_data_out (spi_data_out[i]),
      .writing_done (writing_done[i]),
      .start_signal (tdc_start_signal[i]),
      .spi_start    (spi_start[i]),
      .spi_data_in  (spi_data_in[i]),
      .cs_end       (spi_cs_end[i]),
      .wr_en        (wr_en[i]),
      .result       (result[i])
    );

    // disabled channel holds its master in reset with cs high
    tdc_spi_master #(
      .TDC_SPI_DIV(TDC_SPI_DIV)
    ) tdc_spi_master_i (
      .clk      (clk),
      .rst      (rst || !tdc_enable[i]),
      .start    (spi_start[i]),
      .data_in  (spi_data_in[i]),
      .cs_end   (spi_cs_end[i]),
      .miso     (tdc_dout[i]),
      .data_out (spi_data_out[i]),
      .busy     (spi_busy[i]),
      .cs       (tdc_cs[i]),
      .sck      (tdc_sck[i]),
      .mosi     (tdc_mosi[i])
    );
  end

  fifo_manager #(
    .NUM_CHANNELS    (NUM_CHANNELS),
    .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2),
    .CLKS_PER_BIT    (CLKS_PER_BIT)
  ) fifo_manager_i (
    .clk          (clk),
    .rst          (rst),
    .wr_en        (wr_en),
    .result       (result),
    .writing_done (writing_done),
    .serial_out   (serial_out)
  );

endmodule

// ==== verilog/fifo_manager.sv ====
`timescale 1ns/1ps

module fifo_manager #(
  parameter int NUM_CHANNELS    = 2,
  parameter int FIFO_DEPTH_LOG2 = 6,
  parameter int CLKS_PER_BIT    = 12
) (
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic                     [NUM_CHANNELS-1:0] wr_en,
  input  scanner_pkg::tdc_result_t [NUM_CHANNELS-1:0] result,
  output logic                     [NUM_CHANNELS-1:0] writing_done,
  output logic                                       serial_out
);

  localparam int IW = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1;
  localparam int BW = $clog2(scanner_pkg::WORD_BYTES);

  logic [IW-1:0]           rr_ptr;
  logic [IW-1:0]           grant_idx;
  logic                    grant_valid;
  logic                    fifo_wr;
  logic                    fifo_rd;
  logic                    fifo_full;
  logic                    fifo_empty;
  scanner_pkg::fifo_word_t fifo_din;
  scanner_pkg::fifo_word_t fifo_dout;
  scanner_pkg::fifo_word_t out_word;
  logic                    sending;
  logic [BW-1:0]           byte_cnt;
  logic                    tx_start;
  logic                    tx_busy;

  // search starts one past the last served channel
  always_comb begin
    int cand;
    grant_valid = 1'b0;
    grant_idx   = rr_ptr;
    for (int i = 1; i <= NUM_CHANNELS; i++) begin
      cand = (int'(rr_ptr) + i) % NUM_CHANNELS;
      if (!grant_valid && wr_en[cand]) begin
        grant_valid = 1'b1;
        grant_idx   = IW'(cand);
      end
    end
  end

  // full FIFO holds back the grant
  assign fifo_wr  = grant_valid && !fifo_full;
  assign fifo_din = {scanner_pkg::chan_tag_t'(grant_idx), result[grant_idx]};

  // done pulse lands in the cycle the word is stored
  always_comb begin
    writing_done = '0;
    if (fifo_wr) writing_done[grant_idx] = 1'b1;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rr_ptr <= '0;
    end else if (fifo_wr) begin
      rr_ptr <= grant_idx;
    end
  end

  sync_fifo #(
    .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)
  ) sync_fifo_i (
    .clk   (clk),
    .rst   (rst),
    .wr_en (fifo_wr),
    .din   (fifo_din),
    .rd_en (fifo_rd),
    .dout  (fifo_dout),
    .full  (fifo_full),
    .empty (fifo_empty)
  );

  // pop one word when the serializer is free
  assign fifo_rd  = !sending && !fifo_empty;
  // tx busy rises on the edge that takes the byte
  assign tx_start = sending && !tx_busy;

  always_ff @(posedge clk) begin
    if (rst) begin
      sending  <= 1'b0;
      byte_cnt <= '0;
    end else if (fifo_rd) begin
      sending  <= 1'b1;
      byte_cnt <= '0;
    end else if (tx_start) begin
      byte_cnt <= byte_cnt + 1'b1;
      if (byte_cnt == BW'(scanner_pkg::WORD_BYTES - 1)) sending <= 1'b0;
    end
  end

  // most significant byte goes out first
  always_ff @(posedge clk) begin
    if (fifo_rd) begin
      out_word <= fifo_dout;
    end else if (tx_start) begin
      out_word <= out_word << 8;
    end
  end

  uart_tx #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) uart_tx_i (
    .clk      (clk),
    .rst      (rst),
    .data     (out_word[31:24]),
    .new_data (tx_start),
    .tx       (serial_out),
    .busy     (tx_busy)
  );

endmodule

// ==== verilog/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
  parameter int FIFO_DEPTH_LOG2 = 6
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    wr_en,
  input  scanner_pkg::fifo_word_t din,
  input  logic                    rd_en,
  output scanner_pkg::fifo_word_t dout,
  output logic                    full,
  output logic                    empty
);

  localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;
  localparam int AW    = FIFO_DEPTH_LOG2;

  scanner_pkg::fifo_word_t mem [0:DEPTH-1];

  // extra msb tells full from empty
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

  // oldest word shown ahead of the pop
  assign dout = mem[rd_ptr[AW-1:0]];

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en && !full) wr_ptr <= wr_ptr + 1'b1;
      if (rd_en && !empty) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en && !full) mem[wr_ptr[AW-1:0]] <= din;
  end

endmodule

// ==== verilog/tdc_control.sv ====
`timescale 1ns/1ps

module tdc_control #(
  parameter int SHOT_DIV = 3571
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     enable,
  input  logic                     pause,
  input  logic                     intb,
  input  logic                     spi_busy,
  input  scanner_pkg::byte_t       spi_data_out,
  input  logic                     writing_done,
  output logic                     start_signal,
  output logic                     spi_start,
  output scanner_pkg::byte_t       spi_data_in,
  output logic                     cs_end,
  output logic                     wr_en,
  output scanner_pkg::tdc_result_t result
);

  localparam int SW = $clog2(SHOT_DIV + 1);
  localparam logic [1:0] LAST_BYTE = 2'(scanner_pkg::TDC_RESULT_BYTES);

  typedef enum logic [2:0] {
    S_IDLE,
    S_FIRE,
    S_WAIT_INT,
    S_SEND,
    S_XFER,
    S_WRITE
  } state_t;

  state_t        state;
  logic [SW-1:0] shot_cnt;
  logic          shot_wrap;
  // 0 is the opcode and 1 to 3 the result bytes
  logic [1:0]    byte_idx;
  logic [1:0]    intb_sync;

  assign shot_wrap = (shot_cnt == SW'(SHOT_DIV - 1));

  // free running shot timer
  always_ff @(posedge clk) begin
    if (rst) begin
      shot_cnt <= '0;
    end else if (shot_wrap) begin
      shot_cnt <= '0;
    end else begin
      shot_cnt <= shot_cnt + 1'b1;
    end
  end

  // interrupt from the TDC is asynchronous
  always_ff @(posedge clk) begin
    if (rst) begin
      intb_sync <= 2'b11;
    end else begin
      intb_sync <= {intb_sync[0], intb};
    end
  end

  // disable drops the channel back to idle at once
  always_ff @(posedge clk) begin
    if (rst || !enable) begin
      state    <= S_IDLE;
      byte_idx <= '0;
    end else begin
      case (state)
        // wrap while busy is skipped and not queued
        S_IDLE: if (shot_wrap && !pause) state <= S_FIRE;
        S_FIRE: state <= S_WAIT_INT;
        S_WAIT_INT: begin
          if (!intb_sync[1]) begin
            byte_idx <= '0;
            state    <= S_SEND;
          end
        end
        // start goes out only while the master is free
        S_SEND: if (!spi_busy) state <= S_XFER;
        // master raised busy on the start edge
        S_XFER: begin
          if (!spi_busy) begin
            if (byte_idx == LAST_BYTE) begin
              state <= S_WRITE;
            end else begin
              byte_idx <= byte_idx + 1'b1;
              state    <= S_SEND;
            end
          end
        end
        // result held until the FIFO takes it
        S_WRITE: if (writing_done) state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

  // first result byte ends up most significant
  always_ff @(posedge clk) begin
    if (state == S_XFER && !spi_busy && byte_idx != 2'd0) begin
      result <= {result[15:0], spi_data_out};
    end
  end

  assign start_signal = (state == S_FIRE);
  assign spi_start    = (state == S_SEND) && !spi_busy;
  // dummy bytes clock the result out
  assign spi_data_in  = (byte_idx == 2'd0) ? scanner_pkg::TDC_READ_OPCODE : '0;
  assign cs_end       = (byte_idx == LAST_BYTE);
  assign wr_en        = (state == S_WRITE);

endmodule

// ==== verilog/tdc_spi_master.sv ====
`timescale 1ns/1ps

module tdc_spi_master #(
  parameter int TDC_SPI_DIV = 4
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               start,
  input  scanner_pkg::byte_t data_in,
  input  logic               cs_end,
  input  logic               miso,
  output scanner_pkg::byte_t data_out,
  output logic               busy,
  output logic               cs,
  output logic               sck,
  output logic               mosi
);

  localparam int DW = $clog2(TDC_SPI_DIV + 1);

  logic [DW-1:0]      div_cnt;
  logic               half_tick;
  logic [2:0]         bit_cnt;
  logic               last_byte;
  scanner_pkg::byte_t tx_shift;
  scanner_pkg::byte_t rx_shift;

  // end of one sck half period
  assign half_tick = busy && (div_cnt == DW'(TDC_SPI_DIV - 1));

  // msb out first
  // line parked low while deselected
  assign mosi = cs ? 1'b0 : tx_shift[7];

  always_ff @(posedge clk) begin
    if (rst) begin
      busy      <= 1'b0;
      cs        <= 1'b1;
      sck       <= 1'b0;
      div_cnt   <= '0;
      bit_cnt   <= '0;
      last_byte <= 1'b0;
    end else if (!busy) begin
      div_cnt <= '0;
      if (start) begin
        busy      <= 1'b1;
        // cs drops on the first byte and stays low in between
        cs        <= 1'b0;
        bit_cnt   <= '0;
        last_byte <= cs_end;
      end
    end else if (half_tick) begin
      div_cnt <= '0;
      sck     <= ~sck;
      // falling edge closes a bit
      if (sck) begin
        bit_cnt <= bit_cnt + 1'b1;
        if (bit_cnt == 3'd7) begin
          busy <= 1'b0;
          // only the byte marked with cs_end releases the TDC
          if (last_byte) cs <= 1'b1;
        end
      end
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // sample on rising sck and shift on falling sck
  always_ff @(posedge clk) begin
    if (start && !busy) begin
      tx_shift <= data_in;
    end else if (half_tick && sck) begin
      tx_shift <= {tx_shift[6:0], 1'b0};
    end
    if (half_tick && !sck) rx_shift <= {rx_shift[6:0], miso};
    // received byte valid as busy falls
    if (half_tick && sck && bit_cnt == 3'd7) data_out <= rx_shift;
  end

endmodule

// ==== verilog/main_control.sv ====
`timescale 1ns/1ps

module main_control #(
  parameter int NUM_CHANNELS = 2,
  parameter int CLKS_PER_BIT = 12
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    serial_in,
  output logic [NUM_CHANNELS-1:0] enable,
  output logic                    pause
);

  scanner_pkg::byte_t rx_data;
  logic               rx_valid;

  uart_rx #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) uart_rx_i (
    .clk      (clk),
    .rst      (rst),
    .rx       (serial_in),
    .data     (rx_data),
    .new_data (rx_valid)
  );

  // command byte loads enables and pause together
  // unused enable bits below the pause flag drop out here
  always_ff @(posedge clk) begin
    if (rst) begin
      enable <= '0;
      pause  <= 1'b0;
    end else if (rx_valid) begin
      enable <= rx_data[NUM_CHANNELS-1:0];
      pause  <= rx_data[scanner_pkg::CMD_PAUSE_BIT];
    end
  end

endmodule

// ==== verilog/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx #(
  parameter int CLKS_PER_BIT = 12
) (
  input  logic               clk,
  input  logic               rst,
  input  scanner_pkg::byte_t data,
  input  logic               new_data,
  output logic               tx,
  output logic               busy
);

  localparam int CW = $clog2(CLKS_PER_BIT + 1);

  logic [CW-1:0] cnt;
  logic [3:0]    bit_idx;
  // data bits with the stop bit above them
  logic [8:0]    shift;

  // bit_idx 0 is the start bit and 9 the stop bit
  always_ff @(posedge clk) begin
    if (rst) begin
      busy    <= 1'b0;
      tx      <= 1'b1;
      cnt     <= '0;
      bit_idx <= '0;
    end else if (!busy) begin
      tx <= 1'b1;
      if (new_data) begin
        busy    <= 1'b1;
        tx      <= 1'b0;
        cnt     <= '0;
        bit_idx <= '0;
      end
    end else if (cnt == CW'(CLKS_PER_BIT - 1)) begin
      cnt <= '0;
      if (bit_idx == 4'd9) begin
        // stop bit done so the next byte may start
        busy <= 1'b0;
      end else begin
        tx      <= shift[0];
        bit_idx <= bit_idx + 1'b1;
      end
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // frame shift register
  always_ff @(posedge clk) begin
    if (!busy && new_data) begin
      shift <= {1'b1, data};
    end else if (busy && cnt == CW'(CLKS_PER_BIT - 1) && bit_idx != 4'd9) begin
      shift <= {1'b1, shift[8:1]};
    end
  end

endmodule

// ==== verilog/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx #(
  parameter int CLKS_PER_BIT = 12
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               rx,
  output scanner_pkg::byte_t data,
  output logic               new_data
);

  localparam int CW = $clog2(CLKS_PER_BIT + 1);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

  rx_state_t          state;
  logic [CW-1:0]      cnt;
  logic [2:0]         bit_idx;
  logic [1:0]         rx_sync;
  logic               bit_end;
  scanner_pkg::byte_t shift;

  // last clock of a full bit period
  assign bit_end = (cnt == CW'(CLKS_PER_BIT - 1));

  // line comes in through two flops
  // idle level of the line is high
  always_ff @(posedge clk) begin
    if (rst) begin
      rx_sync <= 2'b11;
    end else begin
      rx_sync <= {rx_sync[0], rx};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= RX_IDLE;
      cnt      <= '0;
      bit_idx  <= '0;
      new_data <= 1'b0;
    end else begin
      new_data <= 1'b0;
      case (state)
        RX_IDLE: begin
          cnt <= '0;
          // falling edge starts a frame
          if (!rx_sync[1]) state <= RX_START;
        end
        RX_START: begin
          // half a bit in we sit at the start bit center
          if (cnt == CW'(CLKS_PER_BIT / 2 - 1)) begin
            cnt     <= '0;
            bit_idx <= '0;
            // glitch shorter than half a bit is dropped
            state   <= rx_sync[1] ? RX_IDLE : RX_DATA;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (bit_end) begin
            cnt     <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) state <= RX_STOP;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        RX_STOP: begin
          if (bit_end) begin
            state    <= RX_IDLE;
            // framing error gives no strobe
            new_data <= rx_sync[1];
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // lsb arrives first so shift in from the top
  always_ff @(posedge clk) begin
    if (state == RX_DATA && bit_end) shift <= {rx_sync[1], shift[7:1]};
    if (state == RX_STOP && bit_end && rx_sync[1]) data <= shift;
  end

endmodule

// ==== verilog/scanner_pkg.sv ====
package scanner_pkg;

  // one byte on the UART or the TDC SPI link
  typedef logic [7:0] byte_t;

  // TDC measurement built from three SPI bytes
  typedef logic [23:0] tdc_result_t;

  // channel index carried in the top byte of a stored word
  typedef logic [7:0] chan_tag_t;

  // tag in bits 31:24 and measurement in bits 23:0
  typedef logic [31:0] fifo_word_t;

  // first byte of every TDC transaction
  // selects the measurement register for readout
  localparam byte_t TDC_READ_OPCODE = 8'h90;

  // bytes clocked in after the opcode
  localparam int TDC_RESULT_BYTES = 3;

  // serial bytes per tagged word
  localparam int WORD_BYTES = 4;

  // pause flag position in a command byte
  // bits below it are the channel enables
  localparam int CMD_PAUSE_BIT = 7;

endpackage
